//--- common/intc_reg_pkg.sv
// register map of the interrupt controller
// pair count, word indices within a bank and the register layout of one pair

package intc_reg_pkg;

    // ******************************
    // sizes
    // ******************************
    localparam int NUM_PAIRS = 4;
    localparam int REG_WORDS = 8;

    localparam int PAIR_W = $clog2(NUM_PAIRS);
    localparam int WORD_W = $clog2(REG_WORDS);

    // byte address: pair bits over a 32 byte bank
    localparam int ADDR_W = PAIR_W + WORD_W + 2;

    // word index inside one bank, byte offset is index * 4
    typedef enum logic [WORD_W-1:0] {
        REG_ACCEL = 3'd0,
        REG_IPC   = 3'd1,
        REG_ERROR = 3'd2,
        REG_S2V   = 3'd3,
        REG_TID   = 3'd4,
        REG_IRQ   = 3'd5,
        REG_SP    = 3'd6,
        REG_SPARE = 3'd7
    } reg_idx_e;

    // accel sits in the low word so that word n of the vector is reg_idx_e n
    typedef struct packed {
        logic [31:0] spare;
        logic [31:0] sp;
        logic [31:0] irq;
        logic [31:0] tid;
        logic [31:0] s2v;
        logic [31:0] error;
        logic [31:0] ipc;
        logic [31:0] accel;
    } int_regs_t;

endpackage

//--- common/intc_ctl_pkg.sv
// control side types of the interrupt controller
// software requests, transfer FSM updates, SIMT core status and warp controls

package intc_ctl_pkg;

    // one software access, no handshake of its own
    typedef struct packed {
        logic                            rd;
        logic                            wr;
        logic [intc_reg_pkg::ADDR_W-1:0] addr;
        logic [31:0]                     data;
    } sw_req_t;

    // register writes requested by the transfer FSM of one pair
    typedef struct packed {
        logic        clr_error;
        logic        set_error;
        logic        clr_s2v;
        logic        save_ipc;
        logic [31:0] ipc;
    } fsm_upd_t;

    // reported by the SIMT core for one pair
    typedef struct packed {
        logic        err;
        logic        pipe_clean;
        logic [31:0] pc;
    } core_status_t;

    // sent back to the SIMT core for one pair
    typedef struct packed {
        logic        hw_int;
        logic        mask_act_warp;
        logic        mask_threads;
        logic        swap_pc;
        logic        restore_pc;
        logic [31:0] new_pc;
    } warp_ctl_t;

    typedef enum logic [2:0] {
        XFER_IDLE,
        XFER_WAIT,
        XFER_PC_SWAP,
        XFER_WAIT_IRQ,
        XFER_REVERT_WARP
    } xfer_state_e;

endpackage

//--- intc/int_regfile.sv
`timescale 1ns/1ps
// interrupt register banks, one bank of eight words per SIMT/scalar pair
// reads are combinational, writes land on the next edge with FSM > SIMT > scalar

module int_regfile (
    input  logic                    clk,
    input  logic                    reset,
    input  intc_ctl_pkg::sw_req_t   simt_req,
    input  intc_ctl_pkg::sw_req_t   scalar_req,
    input  intc_ctl_pkg::fsm_upd_t  fsm_upd [intc_reg_pkg::NUM_PAIRS],
    output logic [31:0]             simt_load,
    output logic [31:0]             scalar_load,
    output intc_reg_pkg::int_regs_t regs [intc_reg_pkg::NUM_PAIRS]
);
    import intc_reg_pkg::*;

    // word view of one bank, index matches reg_idx_e
    typedef logic [REG_WORDS-1:0][31:0] bank_t;

    bank_t bank_q [NUM_PAIRS];
    bank_t bank_d [NUM_PAIRS];

    logic [PAIR_W-1:0] simt_pair;
    logic [PAIR_W-1:0] scalar_pair;
    logic [WORD_W-1:0] simt_word;
    logic [WORD_W-1:0] scalar_word;

    // ******************************
    // address decode
    // ******************************
    // byte lane bits [1:0] are dropped, only whole words exist
    assign simt_pair   = simt_req.addr[ADDR_W-1 -: PAIR_W];
    assign simt_word   = simt_req.addr[2 +: WORD_W];
    assign scalar_pair = scalar_req.addr[ADDR_W-1 -: PAIR_W];
    assign scalar_word = scalar_req.addr[2 +: WORD_W];

    // ******************************
    // read ports
    // ******************************
    assign simt_load   = simt_req.rd ? bank_q[simt_pair][simt_word] : '0;
    assign scalar_load = scalar_req.rd ? bank_q[scalar_pair][scalar_word] : '0;

    // ******************************
    // write merge
    // ******************************
    // lowest priority first, each later write overrides the same word
    always_comb
    begin
        for (int p = 0; p < NUM_PAIRS; p++)
        begin
            bank_d[p] = bank_q[p];

            if (scalar_req.wr && scalar_pair == PAIR_W'(p))
                bank_d[p][scalar_word] = scalar_req.data;

            if (simt_req.wr && simt_pair == PAIR_W'(p))
                bank_d[p][simt_word] = simt_req.data;

            // FSM touches only error, s2v and ipc
            if (fsm_upd[p].clr_error)
                bank_d[p][REG_ERROR] = 32'd0;
            if (fsm_upd[p].set_error)
                bank_d[p][REG_ERROR] = 32'd1;
            if (fsm_upd[p].clr_s2v)
                bank_d[p][REG_S2V] = 32'd0;
            if (fsm_upd[p].save_ipc)
                bank_d[p][REG_IPC] = fsm_upd[p].ipc;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            bank_q <= '{default: '0};
        else
            bank_q <= bank_d;
    end

    // struct view for the transfer FSMs
    for (genvar p = 0; p < NUM_PAIRS; p++)
    begin : g_regs
        assign regs[p] = int_regs_t'(bank_q[p]);
    end

endmodule

//--- intc/thread_xfer_fsm.sv
`timescale 1ns/1ps
// thread transfer sequencer for one SIMT/scalar pair
// watches s2v, talks to the SIMT core through warp controls, updates the bank

module thread_xfer_fsm (
    input  logic                       clk,
    input  logic                       reset,
    input  intc_reg_pkg::int_regs_t    regs,
    input  intc_ctl_pkg::core_status_t status,
    output intc_ctl_pkg::fsm_upd_t     upd,
    output intc_ctl_pkg::warp_ctl_t    ctl
);
    import intc_ctl_pkg::*;

    xfer_state_e state_q;
    xfer_state_e state_d;

    // ******************************
    // next state
    // ******************************
    always_comb
    begin
        state_d = state_q;
        case (state_q)
            XFER_IDLE:
            begin
                if (regs.s2v == 32'd1)
                    state_d = XFER_WAIT;
            end
            XFER_WAIT:
            begin
                // error aborts the transfer before the pc is touched
                if (status.err)
                    state_d = XFER_IDLE;
                else if (status.pipe_clean)
                    state_d = XFER_PC_SWAP;
            end
            XFER_PC_SWAP:
                state_d = XFER_WAIT_IRQ;
            XFER_WAIT_IRQ:
            begin
                // scalar side clears s2v when the handler is done
                if (regs.s2v == 32'd0)
                    state_d = XFER_REVERT_WARP;
            end
            XFER_REVERT_WARP:
                state_d = XFER_IDLE;
            default:
                state_d = XFER_IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            state_q <= XFER_IDLE;
        else
            state_q <= state_d;
    end

    // ******************************
    // outputs
    // ******************************
    always_comb
    begin
        upd = '0;
        ctl = '0;
        case (state_q)
            XFER_IDLE:
            begin
                // new request, forget the last failure
                upd.clr_error = (regs.s2v == 32'd1);
            end
            XFER_WAIT:
            begin
                ctl.hw_int        = 1'b1;
                ctl.mask_act_warp = 1'b1;
                upd.set_error     = status.err;
                upd.clr_s2v       = status.err;
            end
            XFER_PC_SWAP:
            begin
                ctl.hw_int       = 1'b1;
                ctl.mask_threads = 1'b1;
                ctl.swap_pc      = 1'b1;
                ctl.new_pc       = regs.irq;
                // keep the interrupted pc for the return
                upd.save_ipc     = 1'b1;
                upd.ipc          = status.pc;
            end
            XFER_WAIT_IRQ:
            begin
                ctl.hw_int       = 1'b1;
                ctl.mask_threads = 1'b1;
            end
            XFER_REVERT_WARP:
            begin
                ctl.restore_pc = 1'b1;
                ctl.new_pc     = regs.ipc;
            end
            default:
            begin
                ctl = '0;
            end
        endcase
    end

endmodule

//--- intc/status_wb_slave.sv
`timescale 1ns/1ps
// Wishbone classic slave for the scalar core's status accesses
// each bus cycle becomes one request to the register file, ack comes one edge later

module status_wb_slave (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            wb_cyc,
    input  logic                            wb_stb,
    input  logic                            wb_we,
    input  logic [intc_reg_pkg::ADDR_W-1:0] wb_adr,
    input  logic [31:0]                     wb_dat_w,
    output logic                            wb_ack,
    output logic [31:0]                     wb_dat_r,
    output intc_ctl_pkg::sw_req_t           req,
    input  logic [31:0]                     load
);

    logic new_cycle;

    // ******************************
    // request
    // ******************************
    // master still holds stb while ack is up, so no second request then
    assign new_cycle = wb_cyc && wb_stb && !wb_ack;

    always_comb
    begin
        req.rd   = new_cycle && !wb_we;
        req.wr   = new_cycle && wb_we;
        req.addr = wb_adr;
        req.data = wb_dat_w;
    end

    // ******************************
    // response
    // ******************************
    // single cycle ack, no wait states
    always_ff @(posedge clk)
    begin
        if (reset)
            wb_ack <= 1'b0;
        else
            wb_ack <= new_cycle;
    end

    // load is the combinational read of the same cycle
    always_ff @(posedge clk)
    begin
        if (new_cycle && !wb_we)
            wb_dat_r <= load;
    end

endmodule

//--- intc/interrupt_ctl_top.sv
`timescale 1ns/1ps
// interrupt controller top for thread transfer between SIMT and scalar cores
// register file, Wishbone status port and one transfer FSM per pair

module interrupt_ctl_top (
    input  logic                            clk,
    input  logic                            reset,
    input  intc_ctl_pkg::sw_req_t           simt_req,
    output logic [31:0]                     simt_load,
    input  logic                            wb_cyc,
    input  logic                            wb_stb,
    input  logic                            wb_we,
    input  logic [intc_reg_pkg::ADDR_W-1:0] wb_adr,
    input  logic [31:0]                     wb_dat_w,
    // byte lanes are not decoded, all accesses are whole words
    input  logic [3:0]                      wb_sel,
    output logic                            wb_ack,
    output logic [31:0]                     wb_dat_r,
    input  intc_ctl_pkg::core_status_t      core_status [intc_reg_pkg::NUM_PAIRS],
    output intc_ctl_pkg::warp_ctl_t         warp_ctl [intc_reg_pkg::NUM_PAIRS]
);
    import intc_reg_pkg::*;
    import intc_ctl_pkg::*;

    sw_req_t     scalar_req;
    logic [31:0] scalar_load;
    int_regs_t   regs [NUM_PAIRS];
    fsm_upd_t    fsm_upd [NUM_PAIRS];

    int_regfile u_regfile (
        .clk         (clk),
        .reset       (reset),
        .simt_req    (simt_req),
        .scalar_req  (scalar_req),
        .fsm_upd     (fsm_upd),
        .simt_load   (simt_load),
        .scalar_load (scalar_load),
        .regs        (regs)
    );

    status_wb_slave u_wb_slave (
        .clk      (clk),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_ack   (wb_ack),
        .wb_dat_r (wb_dat_r),
        .req      (scalar_req),
        .load     (scalar_load)
    );

    // one sequencer per SIMT/scalar pair
    for (genvar p = 0; p < NUM_PAIRS; p++)
    begin : g_xfer
        thread_xfer_fsm u_xfer (
            .clk    (clk),
            .reset  (reset),
            .regs   (regs[p]),
            .status (core_status[p]),
            .upd    (fsm_upd[p]),
            .ctl    (warp_ctl[p])
        );
    end

endmodule

//--- verif/tb_clkgen.sv
`timescale 1ns/1ps
// clock and reset source for the testbench
// 20 ns clock, synchronous reset held high for the first 4 cycles

module tb_clkgen (
    output logic clk,
    output logic reset
);
    localparam int HALF_PERIOD  = 10;
    localparam int RESET_CYCLES = 4;

    initial
    begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // released on a falling edge like every other input
    initial
    begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

//--- verif/interrupt_ctl_chk.sv
`timescale 1ns/1ps
// protocol checks bound into the interrupt controller top
// Wishbone ack timing, pc pulse width and quiet outputs in reset

module interrupt_ctl_chk (
    input logic                    clk,
    input logic                    reset,
    input logic                    wb_cyc,
    input logic                    wb_stb,
    input logic                    wb_ack,
    input intc_ctl_pkg::warp_ctl_t warp_ctl [intc_reg_pkg::NUM_PAIRS]
);
    import intc_reg_pkg::*;
    import intc_ctl_pkg::*;

    // failures so far, watched by the testbench top
    int   err_count = 0;
    logic ctl_quiet;

    always_comb
    begin
        ctl_quiet = 1'b1;
        for (int p = 0; p < NUM_PAIRS; p++)
        begin
            if (warp_ctl[p] != '0)
                ctl_quiet = 1'b0;
        end
    end

    // ******************************
    // Wishbone
    // ******************************
    ack_after_strobe: assert property (@(posedge clk) disable iff (reset)
        (wb_cyc && wb_stb && !wb_ack) |=> wb_ack)
    else
    begin
        err_count++;
        $error("no wb_ack one cycle after a new strobe");
    end

    ack_one_cycle: assert property (@(posedge clk) disable iff (reset)
        wb_ack |=> !wb_ack)
    else
    begin
        err_count++;
        $error("wb_ack held longer than one cycle");
    end

    // ******************************
    // warp controls
    // ******************************
    for (genvar p = 0; p < NUM_PAIRS; p++)
    begin : g_pair
        pc_pulse: assert property (@(posedge clk) disable iff (reset)
            (warp_ctl[p].swap_pc || warp_ctl[p].restore_pc)
            |=> !(warp_ctl[p].swap_pc || warp_ctl[p].restore_pc))
        else
        begin
            err_count++;
            $error("swap_pc or restore_pc wider than one cycle on pair %0d", p);
        end
    end

    quiet_in_reset: assert property (@(posedge clk) reset |=> (ctl_quiet && !wb_ack))
    else
    begin
        err_count++;
        $error("controls or wb_ack active during reset");
    end

endmodule

bind interrupt_ctl_top interrupt_ctl_chk u_chk (
    .clk      (clk),
    .reset    (reset),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_ack   (wb_ack),
    .warp_ctl (warp_ctl)
);

//--- verif/interrupt_ctl_tb.sv
`timescale 1ns/1ps
// testbench top for the interrupt controller
// random register traffic on both ports, collisions, transfer and error paths

module interrupt_ctl_tb;
    import intc_reg_pkg::*;
    import intc_ctl_pkg::*;

    localparam int TIMEOUT_CYCLES = 2000;
    localparam int SAMPLE_DELAY   = 5;
    localparam int RANDOM_OPS     = 200;

    logic              clk;
    logic              reset;
    sw_req_t           simt_req;
    logic [31:0]       simt_load;
    logic              wb_cyc;
    logic              wb_stb;
    logic              wb_we;
    logic [ADDR_W-1:0] wb_adr;
    logic [31:0]       wb_dat_w;
    logic [3:0]        wb_sel;
    logic              wb_ack;
    logic [31:0]       wb_dat_r;
    core_status_t      core_status [NUM_PAIRS];
    warp_ctl_t         warp_ctl [NUM_PAIRS];

    // shadow of every register word
    logic [31:0] model [NUM_PAIRS][REG_WORDS];
    logic [31:0] lfsr;
    int          cycles = 0;

    tb_clkgen u_clkgen (
        .clk   (clk),
        .reset (reset)
    );

    interrupt_ctl_top DUT (
        .clk         (clk),
        .reset       (reset),
        .simt_req    (simt_req),
        .simt_load   (simt_load),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_sel      (wb_sel),
        .wb_ack      (wb_ack),
        .wb_dat_r    (wb_dat_r),
        .core_status (core_status),
        .warp_ctl    (warp_ctl)
    );

    // ******************************
    // helpers
    // ******************************
    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("FAIL %0t: %s got %08h expected %08h", $time, what, got, exp);
        $display("TEST FAIL");
        $fatal(1, "value mismatch");
    endtask

    task automatic abort_run(input string why);
        $display("%0t: %s", $time, why);
        $display("TEST FAIL");
        $fatal(1, "%s", why);
    endtask

    task automatic check_word(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp)
        else report_mismatch(what, got, exp);
    endtask

    // fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_next(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [ADDR_W-1:0] word_addr(input int pair, input int word);
        return {PAIR_W'(pair), WORD_W'(word), 2'b00};
    endfunction

    // ******************************
    // port drivers entered on a falling edge
    // ******************************
    task automatic simt_write(input int pair, input int word, input logic [31:0] data);
        simt_req.rd   = 1'b0;
        simt_req.wr   = 1'b1;
        simt_req.addr = word_addr(pair, word);
        simt_req.data = data;
        @(negedge clk);
        simt_req = '0;
        model[pair][word] = data;
    endtask

    task automatic simt_read_check(input int pair, input int word);
        simt_req.rd   = 1'b1;
        simt_req.addr = word_addr(pair, word);
        #(SAMPLE_DELAY);
        check_word($sformatf("SIMT read pair %0d word %0d", pair, word),
                   simt_load, model[pair][word]);
        @(negedge clk);
        simt_req = '0;
    endtask

    // returns on the falling edge that sees wb_ack
    task automatic wait_ack();
        do
        begin
            @(negedge clk);
        end
        while (!wb_ack);
    endtask

    task automatic wb_write(input int pair, input int word, input logic [31:0] data);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = word_addr(pair, word);
        wb_dat_w = data;
        wait_ack();
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        model[pair][word] = data;
    endtask

    task automatic wb_read_check(input int pair, input int word);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = word_addr(pair, word);
        wait_ack();
        check_word($sformatf("Wishbone read pair %0d word %0d", pair, word),
                   wb_dat_r, model[pair][word]);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    task automatic check_pair_regs(input int pair);
        for (int w = 0; w < REG_WORDS; w++)
            simt_read_check(pair, w);
    endtask

    task automatic check_others_quiet(input int busy);
        for (int p = 0; p < NUM_PAIRS; p++)
        begin
            if (p != busy)
                assert (warp_ctl[p] == '0)
                else abort_run($sformatf("warp_ctl of pair %0d moved while pair %0d worked",
                                         p, busy));
        end
    endtask

    // after s2v is written to 1 the FSM reaches wait within three cycles
    task automatic wait_for_entry(input int pair);
        int n;
        n = 0;
        do
        begin
            @(negedge clk);
            n++;
        end
        while (!(warp_ctl[pair].hw_int && warp_ctl[pair].mask_act_warp) && n < 3);
        assert (warp_ctl[pair].hw_int && warp_ctl[pair].mask_act_warp)
        else abort_run($sformatf("hw_int and mask_act_warp did not rise on pair %0d", pair));
        model[pair][REG_ERROR] = 32'd0;
    endtask

    // err while in wait drops the transfer
    task automatic abort_with_err(input int pair);
        core_status[pair].err = 1'b1;
        @(negedge clk);
        core_status[pair].err = 1'b0;
        model[pair][REG_ERROR] = 32'd1;
        model[pair][REG_S2V]   = 32'd0;
        assert (warp_ctl[pair] == '0)
        else abort_run($sformatf("warp controls stayed up after err on pair %0d", pair));
    endtask

    // ******************************
    // tests
    // ******************************
    task automatic random_traffic(input int ops);
        logic [31:0] pair_bits;
        logic [31:0] word_bits;
        logic [31:0] kind;
        logic [31:0] data;
        for (int i = 0; i < ops; i++)
        begin
            take_bits(2, pair_bits);
            take_bits(3, word_bits);
            take_bits(2, kind);
            take_bits(32, data);
            // s2v never reads 1 here or that pair would start a transfer
            if (word_bits == REG_S2V)
                data[31] = 1'b1;
            case (kind[1:0])
                2'd0: simt_write(int'(pair_bits), int'(word_bits), data);
                2'd1: simt_read_check(int'(pair_bits), int'(word_bits));
                2'd2: wb_write(int'(pair_bits), int'(word_bits), data);
                default: wb_read_check(int'(pair_bits), int'(word_bits));
            endcase
        end
    endtask

    task automatic collision_test();
        logic [31:0] pair_bits;
        logic [31:0] simt_data;
        logic [31:0] wb_data;
        take_bits(2, pair_bits);
        take_bits(32, simt_data);
        take_bits(32, wb_data);
        simt_req.wr   = 1'b1;
        simt_req.addr = word_addr(int'(pair_bits), REG_SP);
        simt_req.data = simt_data;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = word_addr(int'(pair_bits), REG_SP);
        wb_dat_w = wb_data;
        wait_ack();
        simt_req = '0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        model[pair_bits][REG_SP] = simt_data;
        simt_read_check(int'(pair_bits), REG_SP);
        wb_read_check(int'(pair_bits), REG_SP);
    endtask

    task automatic transfer_test(input int pair);
        logic [31:0] irq_pc;
        logic [31:0] core_pc;
        int          n;
        take_bits(32, irq_pc);
        take_bits(32, core_pc);
        simt_write(pair, REG_IRQ, irq_pc);
        simt_write(pair, REG_S2V, 32'd1);
        wait_for_entry(pair);
        check_others_quiet(pair);

        core_status[pair].pc         = core_pc;
        core_status[pair].pipe_clean = 1'b1;
        @(negedge clk);
        core_status[pair].pipe_clean = 1'b0;
        assert (warp_ctl[pair].swap_pc && warp_ctl[pair].hw_int && warp_ctl[pair].mask_threads)
        else abort_run("no swap_pc after pipe_clean");
        check_word("new_pc in pc swap", warp_ctl[pair].new_pc, irq_pc);
        @(negedge clk);
        assert (!warp_ctl[pair].swap_pc && warp_ctl[pair].hw_int && warp_ctl[pair].mask_threads)
        else abort_run("core left masked state too early after the pc swap");
        model[pair][REG_IPC] = core_pc;
        simt_read_check(pair, REG_IPC);
        check_others_quiet(pair);

        // scalar side is done with the thread
        wb_write(pair, REG_S2V, 32'd0);
        n = 0;
        do
        begin
            @(negedge clk);
            n++;
        end
        while (!warp_ctl[pair].restore_pc && n < 3);
        assert (warp_ctl[pair].restore_pc)
        else abort_run("no restore_pc after s2v was cleared");
        check_word("new_pc in revert warp", warp_ctl[pair].new_pc, core_pc);
        @(negedge clk);
        assert (warp_ctl[pair] == '0)
        else abort_run("warp controls stayed up after the revert");
        check_others_quiet(pair);
    endtask

    task automatic error_test(input int pair);
        simt_write(pair, REG_S2V, 32'd1);
        wait_for_entry(pair);
        simt_read_check(pair, REG_ERROR);
        abort_with_err(pair);
        wb_read_check(pair, REG_ERROR);
        simt_read_check(pair, REG_S2V);
        // a fresh request clears the old error
        simt_write(pair, REG_S2V, 32'd1);
        wait_for_entry(pair);
        wb_read_check(pair, REG_ERROR);
        check_others_quiet(pair);
        abort_with_err(pair);
    endtask

    // ******************************
    // run control
    // ******************************
    always @(posedge clk)
    begin
        if (cycles == TIMEOUT_CYCLES)
            abort_run("timeout, the tests did not finish within the cycle limit");
        else
            cycles = cycles + 1;
    end

    always @(negedge clk)
    begin
        if (DUT.u_chk.err_count != 0)
            abort_run("a bound protocol assertion failed");
    end

    initial
    begin
        logic [31:0] pair_bits;
        int          xfer_pair;
        lfsr     = 32'h7291c9b4;
        simt_req = '0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        wb_sel   = 4'hf;
        for (int p = 0; p < NUM_PAIRS; p++)
        begin
            core_status[p] = '0;
            for (int w = 0; w < REG_WORDS; w++)
                model[p][w] = 32'd0;
        end
        @(negedge reset);
        @(negedge clk);

        assert (!wb_ack)
        else abort_run("wb_ack high after reset");
        check_others_quiet(-1);
        for (int p = 0; p < NUM_PAIRS; p++)
            check_pair_regs(p);
        wb_read_check(NUM_PAIRS - 1, REG_SPARE);

        random_traffic(RANDOM_OPS);
        collision_test();

        take_bits(2, pair_bits);
        xfer_pair = int'(pair_bits);
        transfer_test(xfer_pair);
        for (int p = 0; p < NUM_PAIRS; p++)
            check_pair_regs(p);
        error_test((xfer_pair + 1) % NUM_PAIRS);
        for (int p = 0; p < NUM_PAIRS; p++)
            check_pair_regs(p);

        @(negedge clk);
        if (DUT.u_chk.err_count == 0)
        begin
            $display("TEST PASS");
            $finish;
        end
        else
            abort_run("the bound protocol checker reported errors");
    end

endmodule

//--- build.f
common/intc_reg_pkg.sv
common/intc_ctl_pkg.sv
intc/int_regfile.sv
intc/thread_xfer_fsm.sv
intc/status_wb_slave.sv
intc/interrupt_ctl_top.sv
verif/tb_clkgen.sv
verif/interrupt_ctl_chk.sv
verif/interrupt_ctl_tb.sv

//--- Bender.yml
package:
  name: interrupt_ctl

sources:
  # packages first, the RTL modules use them in their port lists
  - files:
      - common/intc_reg_pkg.sv
      - common/intc_ctl_pkg.sv
  - files:
      - intc/int_regfile.sv
      - intc/thread_xfer_fsm.sv
      - intc/status_wb_slave.sv
      - intc/interrupt_ctl_top.sv
  - target: test
    files:
      - verif/tb_clkgen.sv
      - verif/interrupt_ctl_chk.sv
      - verif/interrupt_ctl_tb.sv
